// File: mem_subsys.f
source/rv_core_pkg.sv
source/rv_lsu_pkg.sv
source/pipe_ifs.sv
source/mem_stage.sv
source/data_ram.sv
source/load_writeback.sv
source/mem_subsys.sv
verif/tb_clock.sv
verif/mem_subsys_props.sv
verif/mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module mem_subsys_tb \
  --Mdir obj_dir -o mem_subsys_sim -f mem_subsys.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_subsys_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$log"; then
  exit 0
fi
echo "Pass line not found in $log"
exit 1

// File: verif/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

  // One table row, stimulus then expected outputs
  typedef struct packed {
    logic                               hold;
    logic [rv_core_pkg::XLEN-1:0]       alures;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic                               regwrite;
    rv_lsu_pkg::load_op_e               load_op;
    rv_lsu_pkg::store_op_e              store_op;
    logic                               exp_regwrite;
    logic [rv_core_pkg::REG_ADDR_W-1:0] exp_rd;
    logic [rv_core_pkg::XLEN-1:0]       exp_res;
  } row_t;

  logic                               bus;
  logic                               rst_n;
  logic                               hold;
  logic [rv_core_pkg::XLEN-1:0]       ex_alures;
  logic [rv_core_pkg::XLEN-1:0]       ex_rs2_data;
  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rs2;
  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd;
  logic                               ex_regwrite;
  logic                               ex_memread;
  logic                               ex_memwrite;
  rv_lsu_pkg::load_op_e               ex_load_op;
  rv_lsu_pkg::store_op_e              ex_store_op;
  logic                               wb_regwrite;
  logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv_core_pkg::XLEN-1:0]       wb_res;

  row_t  rows [$];
  string row_names [$];
  // Byte-wide memory model, index is {word, lane}
  logic [7:0] model_mem [rv_core_pkg::DMEM_WORDS*rv_lsu_pkg::LANES];
  int cycle_count = 0;
  int cycle_limit = 0;

  tb_clock u_clock (.bus(bus));

  mem_subsys UUT (
    .bus(bus), .rst_n(rst_n), .hold(hold),
    .ex_alures(ex_alures), .ex_rs2_data(ex_rs2_data), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
    .ex_regwrite(ex_regwrite), .ex_memread(ex_memread), .ex_memwrite(ex_memwrite),
    .ex_load_op(ex_load_op), .ex_store_op(ex_store_op),
    .wb_regwrite(wb_regwrite), .wb_rd(wb_rd), .wb_res(wb_res)
  );

  bind mem_stage mem_subsys_props u_props (
    .bus(bus), .rst_n(rst_n), .hold(hold), .we(ram.we), .byte_en(byte_en),
    .store_op(ex.store_op), .wb_regwrite(mw.regwrite)
  );

  //////////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input logic hld, input logic [31:0] alures,
                         input logic [31:0] rs2_data, input logic [4:0] rs2,
                         input logic [4:0] rd, input rv_lsu_pkg::load_op_e ld,
                         input rv_lsu_pkg::store_op_e st, input logic regwrite);
    row_t r;
    r = '0;
    r.hold = hld;
    r.alures = alures;
    r.rs2_data = rs2_data;
    r.rs2 = rs2;
    r.rd = rd;
    r.regwrite = regwrite;
    r.load_op = ld;
    r.store_op = st;
    rows.push_back(r);
    row_names.push_back(name);
  endtask

  task automatic add_store(input string name, input rv_lsu_pkg::store_op_e st,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [4:0] rs2, input logic hld);
    add_row(name, hld, addr, data, rs2, 5'd0, rv_lsu_pkg::LD_NONE, st, 1'b0);
  endtask

  task automatic add_load(input string name, input rv_lsu_pkg::load_op_e ld,
                          input logic [31:0] addr, input logic [4:0] rd, input logic hld);
    add_row(name, hld, addr, 32'h0, 5'd0, rd, ld, rv_lsu_pkg::ST_NONE, 1'b1);
  endtask

  task automatic build_table();
    rv_lsu_pkg::load_op_e kinds [4];
    kinds = '{rv_lsu_pkg::LD_B, rv_lsu_pkg::LD_BU, rv_lsu_pkg::LD_H, rv_lsu_pkg::LD_HU};
    // Words 4 to 7 filled with random data, then read back
    for (int k = 0; k < 4; k++)
    begin
      add_store($sformatf("st_w word %0d", 4 + k), rv_lsu_pkg::ST_W,
                32'h10 + 32'(4 * k), $urandom(), 5'd1, 1'b0);
    end
    add_load("ld_w word 4", rv_lsu_pkg::LD_W, 32'h10, 5'd5, 1'b0);
    add_load("ld_w word 7", rv_lsu_pkg::LD_W, 32'h1c, 5'd6, 1'b0);
    // Byte at offset k and halfword at offset k+2, both in word 4+k
    for (int k = 0; k < 4; k++)
    begin
      add_store($sformatf("st_b off %0d", k), rv_lsu_pkg::ST_B,
                32'h10 + 32'(5 * k), 32'h1234_5680 + 32'(17 * k), 5'd2, 1'b0);
      add_store($sformatf("st_h off %0d", (k + 2) % 4), rv_lsu_pkg::ST_H,
                32'h10 + 32'(4 * k + (k + 2) % 4), 32'hdead_5ac3 + 32'(k * 256), 5'd3, 1'b0);
    end
    for (int k = 0; k < 4; k++)
    begin
      add_load($sformatf("ld_w lanes word %0d", 4 + k), rv_lsu_pkg::LD_W,
               32'h10 + 32'(4 * k), 5'd7, 1'b0);
    end
    // Every narrow load kind at every offset
    for (int k = 0; k < 4; k++)
    begin
      for (int off = 0; off < 4; off++)
      begin
        add_load($sformatf("%s off %0d", kinds[k].name(), off), kinds[k],
                 32'h10 + 32'(4 * ((k + off) % 4) + off), 5'd8, 1'b0);
      end
    end
    // ALU result and store forwarding
    add_row("alu rd 9", 1'b0, 32'h1234_5678, 32'h0, 5'd0, 5'd9,
            rv_lsu_pkg::LD_NONE, rv_lsu_pkg::ST_NONE, 1'b1);
    add_store("st_w fwd rs2 9", rv_lsu_pkg::ST_W, 32'h20, 32'hbad0_bad0, 5'd9, 1'b0);
    add_row("alu rd 0", 1'b0, 32'h5555_aaaa, 32'h0, 5'd0, 5'd0,
            rv_lsu_pkg::LD_NONE, rv_lsu_pkg::ST_NONE, 1'b1);
    add_store("st_w rs2 0", rv_lsu_pkg::ST_W, 32'h24, 32'h0f0f_0f0f, 5'd0, 1'b0);
    add_load("ld_w word 8", rv_lsu_pkg::LD_W, 32'h20, 5'd10, 1'b0);
    add_store("st_w fwd load", rv_lsu_pkg::ST_W, 32'h28, 32'hbad1_bad1, 5'd10, 1'b0);
    add_load("ld_w word 9", rv_lsu_pkg::LD_W, 32'h24, 5'd11, 1'b0);
    add_load("ld_w word 10", rv_lsu_pkg::LD_W, 32'h28, 5'd11, 1'b0);
    // Held store never reaches word 8
    add_store("st_w held junk", rv_lsu_pkg::ST_W, 32'h20, 32'hdead_beef, 5'd1, 1'b1);
    add_load("ld_w word 8 kept", rv_lsu_pkg::LD_W, 32'h20, 5'd12, 1'b0);
    // Held load behind a load, the read register must not move
    add_load("ld_b held", rv_lsu_pkg::LD_B, 32'h1d, 5'd13, 1'b1);
    add_load("ld_b released", rv_lsu_pkg::LD_B, 32'h1d, 5'd13, 1'b0);
    // Held store completes once on release
    add_store("st_w held 1", rv_lsu_pkg::ST_W, 32'h2c, 32'h600d_f00d, 5'd1, 1'b1);
    add_store("st_w held 2", rv_lsu_pkg::ST_W, 32'h2c, 32'h600d_f00d, 5'd1, 1'b1);
    add_store("st_w released", rv_lsu_pkg::ST_W, 32'h2c, 32'h600d_f00d, 5'd1, 1'b0);
    add_load("ld_w word 11", rv_lsu_pkg::LD_W, 32'h2c, 5'd14, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////

  // Addressed byte first, then the following lanes of the same word
  function automatic logic [31:0] load_value(input logic [7:0] word, input logic [1:0] off,
                                             input rv_lsu_pkg::load_op_e ld);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = model_mem[{word, off}];
    b1 = model_mem[{word, off + 2'd1}];
    case (ld)
      rv_lsu_pkg::LD_B:  return {{24{b0[7]}}, b0};
      rv_lsu_pkg::LD_BU: return {24'h0, b0};
      rv_lsu_pkg::LD_H:  return {{16{b1[7]}}, b1, b0};
      rv_lsu_pkg::LD_HU: return {16'h0, b1, b0};
      rv_lsu_pkg::LD_W:
        return {model_mem[{word, off + 2'd3}], model_mem[{word, off + 2'd2}], b1, b0};
      default:           return 32'h0;
    endcase
  endfunction

  task automatic predict_table();
    logic        prev_rw;
    logic [4:0]  prev_rd;
    logic [31:0] prev_res;
    logic [31:0] data;
    logic [7:0]  word;
    logic [1:0]  off;
    // Idle instruction after reset
    prev_rw = 1'b0;
    prev_rd = 5'd0;
    prev_res = 32'h0;
    for (int i = 0; i < rows.size(); i++)
    begin
      word = rows[i].alures[9:2];
      off = rows[i].alures[1:0];
      if (!rows[i].hold)
      begin
        // Forward the value in writeback over a stale rs2
        data = rows[i].rs2_data;
        if (rows[i].store_op != rv_lsu_pkg::ST_NONE && prev_rw && prev_rd == rows[i].rs2
            && rows[i].rs2 != 5'd0)
          data = prev_res;
        case (rows[i].store_op)
          rv_lsu_pkg::ST_B: model_mem[{word, off}] = data[7:0];
          rv_lsu_pkg::ST_H:
          begin
            model_mem[{word, off}] = data[7:0];
            model_mem[{word, off + 2'd1}] = data[15:8];
          end
          rv_lsu_pkg::ST_W:
          begin
            for (int j = 0; j < 4; j++)
              model_mem[{word, 2'(j)}] = data[8*j +: 8];
          end
          default: ;
        endcase
        prev_rw = rows[i].regwrite;
        prev_rd = rows[i].rd;
        prev_res = (rows[i].load_op != rv_lsu_pkg::LD_NONE)
                 ? load_value(word, off, rows[i].load_op) : rows[i].alures;
      end
      // Held rows repeat the previous outputs
      rows[i].exp_regwrite = prev_rw;
      rows[i].exp_rd = prev_rd;
      rows[i].exp_res = prev_res;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////////////////////////////

  task automatic drive_row(input row_t r);
    hold = r.hold;
    ex_alures = r.alures;
    ex_rs2_data = r.rs2_data;
    ex_rs2 = r.rs2;
    ex_rd = r.rd;
    ex_regwrite = r.regwrite;
    ex_memread = (r.load_op != rv_lsu_pkg::LD_NONE);
    ex_memwrite = (r.store_op != rv_lsu_pkg::ST_NONE);
    ex_load_op = r.load_op;
    ex_store_op = r.store_op;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Run limit from the table length
  always @(posedge bus)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
    begin
      $display("timeout: run went past %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    void'($urandom(7100));
    rst_n = 1'b0;
    hold = 1'b0;
    ex_alures = '0;
    ex_rs2_data = '0;
    ex_rs2 = '0;
    ex_rd = '0;
    ex_regwrite = 1'b0;
    ex_memread = 1'b0;
    ex_memwrite = 1'b0;
    ex_load_op = rv_lsu_pkg::LD_NONE;
    ex_store_op = rv_lsu_pkg::ST_NONE;
    build_table();
    predict_table();
    cycle_limit = (rows.size() + 20) * 2;
    repeat (2) @(posedge bus);
    #1 rst_n = 1'b1;
    @(posedge bus);
    #1;
    // Each row is sampled at the next edge, outputs checked 1 ns later
    for (int i = 0; i < rows.size(); i++)
    begin
      drive_row(rows[i]);
      @(posedge bus);
      #1;
      check_value({row_names[i], " wb_regwrite"}, 32'(rows[i].exp_regwrite), 32'(wb_regwrite));
      check_value({row_names[i], " wb_rd"}, 32'(rows[i].exp_rd), 32'(wb_rd));
      check_value({row_names[i], " wb_res"}, rows[i].exp_res, wb_res);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: verif/mem_subsys_props.sv
`timescale 1ns/1ps

module mem_subsys_props (
  input logic                         bus,
  input logic                         rst_n,
  input logic                         hold,
  input logic                         we,
  input logic [rv_lsu_pkg::LANES-1:0] byte_en,
  input rv_lsu_pkg::store_op_e        store_op,
  input logic                         wb_regwrite
);

  // Frozen stage leaves the RAM alone
  no_write_on_hold: assert property (
    @(posedge bus) disable iff (!rst_n) hold |-> !we)
    else $error("RAM write enable high while hold is asserted");

  // Byte store touches exactly one lane
  byte_store_one_lane: assert property (
    @(posedge bus) disable iff (!rst_n)
    (store_op == rv_lsu_pkg::ST_B) |-> $onehot(byte_en))
    else $error("byte store enables other than one lane");

  // First edge out of reset sees an empty MEM/WB register
  regwrite_low_after_reset: assert property (
    @(posedge bus) $rose(rst_n) |-> !wb_regwrite)
    else $error("MEM/WB regwrite set right after reset");

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic bus
);

  // 8 ns period, low for the first half
  initial
  begin
    bus = 1'b0;
    forever
    begin
      #4 bus = ~bus;
    end
  end

endmodule

// File: source/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
  input  logic                               bus,
  input  logic                               rst_n,
  input  logic                               hold,
  // EX/MEM bundle
  input  logic [rv_core_pkg::XLEN-1:0]       ex_alures,
  input  logic [rv_core_pkg::XLEN-1:0]       ex_rs2_data,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rs2,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rd,
  input  logic                               ex_regwrite,
  input  logic                               ex_memread,
  input  logic                               ex_memwrite,
  input  rv_lsu_pkg::load_op_e               ex_load_op,
  input  rv_lsu_pkg::store_op_e              ex_store_op,
  // Writeback result
  output logic                               wb_regwrite,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_core_pkg::XLEN-1:0]       wb_res
);

  ex_mem_if ex_bus ();
  ram_if    ram_bus ();
  mem_wb_if mw_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM ports onto the bundle
  ////////////////////////////////////////////////////////////////////////////

  assign ex_bus.alures   = ex_alures;
  assign ex_bus.rs2_data = ex_rs2_data;
  assign ex_bus.rs2      = ex_rs2;
  assign ex_bus.rd       = ex_rd;
  assign ex_bus.regwrite = ex_regwrite;
  assign ex_bus.memread  = ex_memread;
  assign ex_bus.memwrite = ex_memwrite;
  assign ex_bus.load_op  = ex_load_op;
  assign ex_bus.store_op = ex_store_op;

  ////////////////////////////////////////////////////////////////////////////
  // Stage, memory and writeback
  ////////////////////////////////////////////////////////////////////////////

  // wb_res loops back into the stage for store forwarding
  mem_stage u_mem_stage (
    .bus    (bus),
    .rst_n  (rst_n),
    .hold   (hold),
    .ex     (ex_bus.stage),
    .ram    (ram_bus.req),
    .mw     (mw_bus.stage),
    .wb_res (wb_res)
  );

  data_ram u_data_ram (
    .bus   (bus),
    .rst_n (rst_n),
    .port  (ram_bus.mem)
  );

  load_writeback u_load_writeback (
    .mw          (mw_bus.wb),
    .wb_regwrite (wb_regwrite),
    .wb_rd       (wb_rd),
    .wb_res      (wb_res)
  );

endmodule

// File: source/load_writeback.sv
`timescale 1ns/1ps

module load_writeback (
  mem_wb_if.wb                               mw,
  output logic                               wb_regwrite,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_core_pkg::XLEN-1:0]       wb_res
);

  // Doubled RAM word, rotated right by the byte offset
  logic [2*rv_core_pkg::XLEN-1:0]   ld_wide;
  logic [rv_core_pkg::XLEN-1:0]     ld_word;
  // Low byte and halfword after the rotate
  logic [rv_lsu_pkg::BYTE_W-1:0]    ld_byte;
  logic [2*rv_lsu_pkg::BYTE_W-1:0]  ld_half;
  logic [rv_core_pkg::XLEN-1:0]     ld_res;

  // Addressed byte lands in lane 0
  assign ld_wide = {mw.ram_dout, mw.ram_dout} >> (mw.lane_sel * rv_lsu_pkg::BYTE_W);
  assign ld_word = ld_wide[rv_core_pkg::XLEN-1:0];
  assign ld_byte = ld_word[rv_lsu_pkg::BYTE_W-1:0];
  assign ld_half = ld_word[2*rv_lsu_pkg::BYTE_W-1:0];

  // Extension by load kind
  always_comb
  begin
    unique case (mw.load_op)
      rv_lsu_pkg::LD_B:
        ld_res = {{(rv_core_pkg::XLEN-rv_lsu_pkg::BYTE_W){ld_byte[rv_lsu_pkg::BYTE_W-1]}},
                  ld_byte};
      rv_lsu_pkg::LD_H:
        ld_res = {{(rv_core_pkg::XLEN-2*rv_lsu_pkg::BYTE_W){ld_half[2*rv_lsu_pkg::BYTE_W-1]}},
                  ld_half};
      rv_lsu_pkg::LD_W:
        ld_res = ld_word;
      rv_lsu_pkg::LD_BU:
        ld_res = {{(rv_core_pkg::XLEN-rv_lsu_pkg::BYTE_W){1'b0}}, ld_byte};
      rv_lsu_pkg::LD_HU:
        ld_res = {{(rv_core_pkg::XLEN-2*rv_lsu_pkg::BYTE_W){1'b0}}, ld_half};
      // LD_NONE and unused codes
      default:
        ld_res = '0;
    endcase
  end

  // Memory result only for loads, ALU result for everything else
  assign wb_res = mw.memread ? ld_res : mw.alures;

  // Destination straight from the MEM/WB register
  assign wb_rd       = mw.rd;
  assign wb_regwrite = mw.regwrite;

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input logic bus,
  input logic rst_n,
  ram_if.mem  port
);

  // One row per word
  logic [rv_core_pkg::XLEN-1:0] mem [rv_core_pkg::DMEM_WORDS];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Each lane has its own enable, maps onto the BRAM byte-write enables
  always_ff @(posedge bus)
  begin
    for (int i = 0; i < rv_lsu_pkg::LANES; i++)
    begin
      if (port.we && port.byte_en[i])
      begin
        mem[port.word_addr][i*rv_lsu_pkg::BYTE_W +: rv_lsu_pkg::BYTE_W]
          <= port.din[i*rv_lsu_pkg::BYTE_W +: rv_lsu_pkg::BYTE_W];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Registered output, old data on a same-edge write
  // Holds its value while re is low
  always_ff @(posedge bus or negedge rst_n)
  begin
    if (!rst_n)
    begin
      port.dout <= '0;
    end
    else if (port.re)
    begin
      port.dout <= mem[port.word_addr];
    end
  end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                         bus,
  input  logic                         rst_n,
  input  logic                         hold,
  ex_mem_if.stage                      ex,
  ram_if.req                           ram,
  mem_wb_if.stage                      mw,
  input  logic [rv_core_pkg::XLEN-1:0] wb_res
);

  // Byte offset within the addressed word
  logic [rv_lsu_pkg::LANE_SEL_W-1:0] lane_sel;
  // Halfword mask before the wrap is folded back in
  logic [2*rv_lsu_pkg::LANES-1:0]    half_wide;
  logic [rv_lsu_pkg::LANES-1:0]      byte_en;
  // Store operand after forwarding
  logic                              fwd_hit;
  logic [rv_core_pkg::XLEN-1:0]      st_data;
  // Rotate amount in bytes, and the doubled word it is taken from
  logic [rv_lsu_pkg::LANE_SEL_W-1:0] st_rot;
  logic [2*rv_core_pkg::XLEN-1:0]    st_wide;

  assign lane_sel = ex.alures[rv_lsu_pkg::LANE_SEL_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Store lane enables
  ////////////////////////////////////////////////////////////////////////////

  // Upper half catches the lane that spills past lane 3
  assign half_wide = {{rv_lsu_pkg::LANES{1'b0}}, rv_lsu_pkg::HALF_MASK} << lane_sel;

  always_comb
  begin
    byte_en = '0;
    unique case (ex.store_op)
      rv_lsu_pkg::ST_NONE:
        byte_en = '0;
      rv_lsu_pkg::ST_B:
        byte_en = rv_lsu_pkg::BYTE_MASK << lane_sel;
      rv_lsu_pkg::ST_H:
      begin
        // Offset 3 wraps into lane 0 of the same word
        byte_en = half_wide[rv_lsu_pkg::LANES-1:0]
                | half_wide[2*rv_lsu_pkg::LANES-1:rv_lsu_pkg::LANES];
      end
      rv_lsu_pkg::ST_W:
        byte_en = '1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store data
  ////////////////////////////////////////////////////////////////////////////

  // Writeback result overrides a stale rs2 operand
  // x0 never forwards
  assign fwd_hit = ex.memwrite && mw.regwrite && (mw.rd == ex.rs2) && (ex.rs2 != '0);
  assign st_data = fwd_hit ? wb_res : ex.rs2_data;

  // Word stores keep their byte order
  assign st_rot = (ex.store_op == rv_lsu_pkg::ST_W) ? '0 : lane_sel;

  // Rotate left by whole bytes, upper half of the doubled word
  assign st_wide = {st_data, st_data} << (st_rot * rv_lsu_pkg::BYTE_W);

  ////////////////////////////////////////////////////////////////////////////
  // RAM request
  ////////////////////////////////////////////////////////////////////////////

  assign ram.word_addr = ex.alures[rv_lsu_pkg::LANE_SEL_W +: rv_core_pkg::DMEM_ADDR_W];
  assign ram.din       = st_wide[2*rv_core_pkg::XLEN-1:rv_core_pkg::XLEN];
  assign ram.byte_en   = byte_en;
  // Frozen stage neither writes nor refreshes the read register
  assign ram.we        = ex.memwrite & ~hold;
  assign ram.re        = ex.memread & ~hold;

  // Read data lines up with the MEM/WB register, passed straight on
  assign mw.ram_dout = ram.dout;

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////////////////////

  // Control half
  always_ff @(posedge bus or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mw.regwrite <= 1'b0;
      mw.memread  <= 1'b0;
      mw.rd       <= '0;
      mw.load_op  <= rv_lsu_pkg::LD_NONE;
    end
    else if (!hold)
    begin
      mw.regwrite <= ex.regwrite;
      mw.memread  <= ex.memread;
      mw.rd       <= ex.rd;
      mw.load_op  <= ex.load_op;
    end
  end

  // Payload half
  always_ff @(posedge bus)
  begin
    if (!hold)
    begin
      mw.alures   <= ex.alures;
      mw.lane_sel <= lane_sel;
    end
  end

endmodule

// File: source/pipe_ifs.sv
`timescale 1ns/1ps

// EX/MEM bundle as it leaves the execute stage
interface ex_mem_if;

  // ALU result, also the byte address of loads and stores
  logic [rv_core_pkg::XLEN-1:0]       alures;
  // Second source operand, the raw store data
  logic [rv_core_pkg::XLEN-1:0]       rs2_data;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
  // Control levels
  logic                               regwrite;
  logic                               memread;
  logic                               memwrite;
  rv_lsu_pkg::load_op_e               load_op;
  rv_lsu_pkg::store_op_e              store_op;

  modport stage (
    input alures,
    input rs2_data,
    input rs2,
    input rd,
    input regwrite,
    input memread,
    input memwrite,
    input load_op,
    input store_op
  );

endinterface

// Word-wide RAM port with per-lane write enables
interface ram_if;

  logic [rv_core_pkg::DMEM_ADDR_W-1:0] word_addr;
  logic [rv_core_pkg::XLEN-1:0]        din;
  logic [rv_lsu_pkg::LANES-1:0]        byte_en;
  logic                                we;
  logic                                re;
  // Registered read data back from the array
  logic [rv_core_pkg::XLEN-1:0]        dout;

  modport req (output word_addr, output din, output byte_en, output we, output re,
               input dout);

  modport mem (input word_addr, input din, input byte_en, input we, input re,
               output dout);

endinterface

// MEM/WB register contents toward writeback
interface mem_wb_if;

  logic [rv_core_pkg::XLEN-1:0]       alures;
  logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
  logic                               regwrite;
  logic                               memread;
  rv_lsu_pkg::load_op_e               load_op;
  // Byte offset of the load, drives the rotate
  logic [rv_lsu_pkg::LANE_SEL_W-1:0]  lane_sel;
  // RAM output, already aligned with this register
  logic [rv_core_pkg::XLEN-1:0]       ram_dout;

  modport stage (output alures, output rd, output regwrite, output memread,
                 output load_op, output lane_sel, output ram_dout);

  modport wb (input alures, input rd, input regwrite, input memread,
              input load_op, input lane_sel, input ram_dout);

endinterface

// File: source/rv_lsu_pkg.sv
package rv_lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////////////////////

  // Bits per lane
  localparam int unsigned BYTE_W = 8;

  // Lanes per data word
  localparam int unsigned LANES = rv_core_pkg::XLEN / BYTE_W;

  // Byte offset inside a word, low address bits
  localparam int unsigned LANE_SEL_W = $clog2(LANES);

  // Lane patterns at offset zero
  // Shifted up by the byte offset in the store path
  localparam logic [LANES-1:0] BYTE_MASK = 'd1;
  localparam logic [LANES-1:0] HALF_MASK = 'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Load and store kinds
  ////////////////////////////////////////////////////////////////////////////

  // Load kind, decoded from funct3 upstream
  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_B    = 3'd1,
    LD_H    = 3'd2,
    LD_W    = 3'd3,
    LD_BU   = 3'd4,
    LD_HU   = 3'd5
  } load_op_e;

  // Store kind
  typedef enum logic [1:0] {
    ST_NONE = 2'd0,
    ST_B    = 2'd1,
    ST_H    = 2'd2,
    ST_W    = 2'd3
  } store_op_e;

endpackage

// File: source/rv_core_pkg.sv
package rv_core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////

  // Architectural data word, RV32
  localparam int unsigned XLEN = 32;

  // Register number, x0 to x31
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Data memory geometry
  ////////////////////////////////////////////////////////////////////////////

  // Depth in words
  // One row holds one full XLEN word
  localparam int unsigned DMEM_WORDS = 256;

  // Word index width
  // Byte offset bits of the address are not part of it
  localparam int unsigned DMEM_ADDR_W = $clog2(DMEM_WORDS);

endpackage
